//--- hdl/rd_dma_defs.svh
`ifndef RD_DMA_DEFS_SVH
`define RD_DMA_DEFS_SVH

// Number of accelerators served by the engine
`define ACCEL_COUNT 4

// Bytes in one scratchpad line, each bank returns one line per read
`define LINE_BYTES 8

// Byte address width, 1 KB of scratchpad over both banks
`define ADDR_BITS 10

// Descriptor length width in bytes
`define LEN_BITS 8

// Output queue depth, also the credit limit per accelerator
`define QUEUE_LINES 2

`endif

//--- hdl/dma_desc_pkg.sv
`include "rd_dma_defs.svh"

package dma_desc_pkg;

  // Descriptor fields
  typedef logic [$clog2(`ACCEL_COUNT)-1:0] accel_id_t;
  typedef logic [`ADDR_BITS-1:0]           byte_addr_t;
  typedef logic [`LEN_BITS-1:0]            byte_len_t;

  // Line level view of a descriptor
  typedef logic [`ADDR_BITS-$clog2(`LINE_BYTES)-1:0]  line_addr_t;
  typedef logic [`LEN_BITS-$clog2(`LINE_BYTES):0]     line_cnt_t;
  typedef logic [$clog2(`LINE_BYTES)-1:0]             byte_ptr_t;

  typedef logic [`ACCEL_COUNT-1:0]         accel_mask_t;
  typedef logic [$clog2(`QUEUE_LINES):0]   credit_t;

  // Where the line fetch of the current cycle comes from
  typedef enum logic [1:0] {
    ISSUE_IDLE,
    ISSUE_NEW,
    ISSUE_ACTIVE
  } issue_src_t;

endpackage

//--- hdl/spm_bank_pkg.sv
`include "rd_dma_defs.svh"

package spm_bank_pkg;

  // Line index inside one bank, even lines in bank0 and odd lines in bank1
  typedef logic [`ADDR_BITS-$clog2(`LINE_BYTES)-2:0] bank_addr_t;

  // One line as read from a bank
  typedef logic [8*`LINE_BYTES-1:0] line_data_t;

  // Two consecutive lines before realignment
  typedef logic [16*`LINE_BYTES-1:0] line_pair_t;

endpackage

//--- hdl/rd_dma_if.sv
`timescale 1ns/1ns

// Line fetch request from the controller to the bank reader
interface line_req_if;
  import dma_desc_pkg::*;

  logic       valid;
  line_addr_t line_addr;
  byte_ptr_t  offset;
  byte_ptr_t  ptr;
  logic       last;
  accel_id_t  dest;

  // No ready, queue credits guarantee room downstream
  modport source (output valid, line_addr, offset, ptr, last, dest);
  modport sink   (input  valid, line_addr, offset, ptr, last, dest);
endinterface

// Realigned line broadcast to all output queues
interface aligned_line_if;
  import dma_desc_pkg::*;
  import spm_bank_pkg::*;

  logic       valid;
  line_data_t data;
  byte_ptr_t  ptr;
  logic       last;
  accel_id_t  dest;

  modport source (output valid, data, ptr, last, dest);
  modport sink   (input  valid, data, ptr, last, dest);
endinterface

//--- hdl/dma_ctrl.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module dma_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_desc_pkg::accel_id_t   desc_accel_id,
  input  dma_desc_pkg::byte_addr_t  desc_addr,
  input  dma_desc_pkg::byte_len_t   desc_len,
  input  logic                      desc_valid,
  input  dma_desc_pkg::accel_mask_t pop,
  input  dma_desc_pkg::accel_mask_t pop_last,
  output dma_desc_pkg::accel_mask_t accel_busy,
  output dma_desc_pkg::accel_mask_t desc_error,
  line_req_if.source                req
);
  import dma_desc_pkg::*;

  localparam int PTR_W = $bits(byte_ptr_t);
  localparam int ADDR_W = $bits(byte_addr_t);

  // Registered descriptor
  logic        accept;
  accel_mask_t accept_mask;
  logic        new_v;
  accel_id_t   new_dest;
  line_addr_t  new_addr;
  byte_ptr_t   new_off;
  byte_ptr_t   new_fptr;
  line_cnt_t   new_cnt;

  // Active table, one entry per accelerator
  accel_mask_t act_v;
  line_addr_t  act_addr [`ACCEL_COUNT];
  line_cnt_t   act_cnt  [`ACCEL_COUNT];
  byte_ptr_t   act_off  [`ACCEL_COUNT];
  byte_ptr_t   act_fptr [`ACCEL_COUNT];
  credit_t     credit   [`ACCEL_COUNT];

  // Arbitration and the selected fetch
  accel_mask_t eligible;
  accel_id_t   rr_last;
  accel_id_t   scan_id;
  accel_id_t   grant_id;
  logic        grant_v;
  issue_src_t  src;
  accel_id_t   sel_dest;
  line_addr_t  sel_addr;
  line_cnt_t   sel_cnt;
  byte_ptr_t   sel_off;
  byte_ptr_t   sel_fptr;
  logic        sel_last;
  accel_mask_t issue_mask;

  // A descriptor for a busy accelerator is dropped
  assign accept      = desc_valid && !accel_busy[desc_accel_id];
  assign accept_mask = accept ? accel_mask_t'(1) << desc_accel_id : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      new_v <= 1'b0;
    end else begin
      new_v <= accept;
    end
  end

  // Split into line address, offset, line count and final byte pointer
  always_ff @(posedge clk) begin
    new_dest <= desc_accel_id;
    new_addr <= desc_addr[ADDR_W-1:PTR_W];
    new_off  <= desc_addr[PTR_W-1:0];
    new_fptr <= desc_len[PTR_W-1:0] - 1'b1;
    new_cnt  <= line_cnt_t'(desc_len >> PTR_W) + line_cnt_t'(|desc_len[PTR_W-1:0]);
  end

  always_comb begin
    for (int i = 0; i < `ACCEL_COUNT; i++) begin
      eligible[i] = act_v[i] && (credit[i] < credit_t'(`QUEUE_LINES));
    end
  end

  // Round-robin scan starting after the last granted entry
  always_comb begin
    grant_v  = 1'b0;
    grant_id = '0;
    scan_id  = '0;
    for (int i = 1; i <= `ACCEL_COUNT; i++) begin
      scan_id = rr_last + accel_id_t'(i);
      if (!grant_v && eligible[scan_id]) begin
        grant_v  = 1'b1;
        grant_id = scan_id;
      end
    end
  end

  // A freshly registered descriptor wins over the active entries
  always_comb begin
    if (new_v) begin
      src = ISSUE_NEW;
    end else if (grant_v) begin
      src = ISSUE_ACTIVE;
    end else begin
      src = ISSUE_IDLE;
    end
  end

  always_comb begin
    case (src)
      ISSUE_NEW: begin
        sel_dest = new_dest;
        sel_addr = new_addr;
        sel_cnt  = new_cnt;
        sel_off  = new_off;
        sel_fptr = new_fptr;
      end
      default: begin
        sel_dest = grant_id;
        sel_addr = act_addr[grant_id];
        sel_cnt  = act_cnt[grant_id];
        sel_off  = act_off[grant_id];
        sel_fptr = act_fptr[grant_id];
      end
    endcase
  end

  assign sel_last   = (sel_cnt == line_cnt_t'(1));
  assign issue_mask = (src != ISSUE_IDLE) ? accel_mask_t'(1) << sel_dest : '0;

  assign req.valid     = (src != ISSUE_IDLE);
  assign req.line_addr = sel_addr;
  assign req.offset    = sel_off;
  assign req.ptr       = sel_last ? sel_fptr : '1;
  assign req.last      = sel_last;
  assign req.dest      = sel_dest;

  // Entry keeps the next line and what is left
  always_ff @(posedge clk) begin
    if (src != ISSUE_IDLE) begin
      act_addr[sel_dest] <= sel_addr + 1'b1;
      act_cnt[sel_dest]  <= sel_cnt - 1'b1;
      act_off[sel_dest]  <= sel_off;
      act_fptr[sel_dest] <= sel_fptr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_v   <= '0;
      rr_last <= '1;
    end else begin
      if (src != ISSUE_IDLE) begin
        act_v[sel_dest] <= !sel_last;
      end
      if (src == ISSUE_ACTIVE) begin
        rr_last <= grant_id;
      end
    end
  end

  // Outstanding lines per queue, counted from issue to pop
  always_ff @(posedge clk) begin
    for (int i = 0; i < `ACCEL_COUNT; i++) begin
      if (rst) begin
        credit[i] <= '0;
      end else if (issue_mask[i] && !pop[i]) begin
        credit[i] <= credit[i] + 1'b1;
      end else if (!issue_mask[i] && pop[i]) begin
        credit[i] <= credit[i] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      accel_busy <= '0;
      desc_error <= '0;
    end else begin
      accel_busy <= (accel_busy & ~pop_last) | accept_mask;
      if (desc_valid && accel_busy[desc_accel_id]) begin
        desc_error[desc_accel_id] <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/bank_reader.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module bank_reader (
  input  logic                     clk,
  input  logic                     rst,
  line_req_if.sink                 req,
  output logic                     bank0_rd_en,
  output spm_bank_pkg::bank_addr_t bank0_rd_addr,
  input  spm_bank_pkg::line_data_t bank0_rd_data,
  output logic                     bank1_rd_en,
  output spm_bank_pkg::bank_addr_t bank1_rd_addr,
  input  spm_bank_pkg::line_data_t bank1_rd_data,
  aligned_line_if.source           line
);
  import dma_desc_pkg::*;
  import spm_bank_pkg::*;

  localparam int LA_W = $bits(line_addr_t);

  line_addr_t next_addr;

  // Metadata delay line, stage 2 lines up with the returned data
  logic [2:0] vld_d;
  logic [2:0] last_d;
  logic [2:0] odd_d;
  accel_id_t  dest_d [3];
  byte_ptr_t  ptr_d  [3];
  byte_ptr_t  off_d  [3];

  line_pair_t pair;
  line_pair_t shifted;

  assign next_addr = req.line_addr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      bank0_rd_en <= 1'b0;
      bank1_rd_en <= 1'b0;
    end else begin
      bank0_rd_en <= req.valid;
      bank1_rd_en <= req.valid;
    end
  end

  // Odd start line sits in bank1 and its successor in bank0
  always_ff @(posedge clk) begin
    if (req.line_addr[0]) begin
      bank0_rd_addr <= next_addr[LA_W-1:1];
      bank1_rd_addr <= req.line_addr[LA_W-1:1];
    end else begin
      bank0_rd_addr <= req.line_addr[LA_W-1:1];
      bank1_rd_addr <= next_addr[LA_W-1:1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_d <= '0;
    end else begin
      vld_d <= {vld_d[1:0], req.valid};
    end
  end

  always_ff @(posedge clk) begin
    last_d    <= {last_d[1:0], req.last};
    odd_d     <= {odd_d[1:0], req.line_addr[0]};
    dest_d[0] <= req.dest;
    ptr_d[0]  <= req.ptr;
    off_d[0]  <= req.offset;
    for (int i = 1; i < 3; i++) begin
      dest_d[i] <= dest_d[i-1];
      ptr_d[i]  <= ptr_d[i-1];
      off_d[i]  <= off_d[i-1];
    end
  end

  // Requested line goes to the lower half, then drop the offset bytes
  always_comb begin
    if (odd_d[2]) begin
      pair = {bank0_rd_data, bank1_rd_data};
    end else begin
      pair = {bank1_rd_data, bank0_rd_data};
    end
    shifted = pair >> {off_d[2], 3'b000};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line.valid <= 1'b0;
    end else begin
      line.valid <= vld_d[2];
    end
  end

  always_ff @(posedge clk) begin
    line.data <= shifted[8*`LINE_BYTES-1:0];
    line.ptr  <= ptr_d[2];
    line.last <= last_d[2];
    line.dest <= dest_d[2];
  end

endmodule

//--- hdl/accel_out_queue.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module accel_out_queue #(
  parameter int ACCEL_INDEX = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  aligned_line_if.sink             line,
  output spm_bank_pkg::line_data_t tdata,
  output dma_desc_pkg::byte_ptr_t  tuser,
  output logic                     tlast,
  output logic                     tvalid,
  input  logic                     tready,
  output logic                     pop,
  output logic                     is_last
);
  import dma_desc_pkg::*;
  import spm_bank_pkg::*;

  localparam int PTR_W = $clog2(`QUEUE_LINES);

  line_data_t       data_q [`QUEUE_LINES];
  byte_ptr_t        ptr_q  [`QUEUE_LINES];
  logic             last_q [`QUEUE_LINES];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          fill;
  logic             wr;

  // Credits keep the writer from ever finding the queue full
  assign wr = line.valid && (line.dest == accel_id_t'(ACCEL_INDEX));

  always_ff @(posedge clk) begin
    if (wr) begin
      data_q[wr_ptr] <= line.data;
      ptr_q[wr_ptr]  <= line.ptr;
      last_q[wr_ptr] <= line.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill <= fill + credit_t'(wr) - credit_t'(pop);
    end
  end

  // Head entry stays put until accepted
  assign tvalid  = (fill != '0);
  assign tdata   = data_q[rd_ptr];
  assign tuser   = ptr_q[rd_ptr];
  assign tlast   = last_q[rd_ptr];
  assign pop     = tvalid && tready;
  assign is_last = pop && tlast;

endmodule

//--- hdl/accel_rd_dma.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module accel_rd_dma (
  input  logic                                       clk,
  input  logic                                       rst,
  input  dma_desc_pkg::accel_id_t                    desc_accel_id,
  input  dma_desc_pkg::byte_addr_t                   desc_addr,
  input  dma_desc_pkg::byte_len_t                    desc_len,
  input  logic                                       desc_valid,
  output dma_desc_pkg::accel_mask_t                  accel_busy,
  output dma_desc_pkg::accel_mask_t                  desc_error,
  output logic                                       bank0_rd_en,
  output spm_bank_pkg::bank_addr_t                   bank0_rd_addr,
  input  spm_bank_pkg::line_data_t                   bank0_rd_data,
  output logic                                       bank1_rd_en,
  output spm_bank_pkg::bank_addr_t                   bank1_rd_addr,
  input  spm_bank_pkg::line_data_t                   bank1_rd_data,
  output logic [`ACCEL_COUNT*8*`LINE_BYTES-1:0]      m_axis_tdata,
  output logic [`ACCEL_COUNT*$clog2(`LINE_BYTES)-1:0] m_axis_tuser,
  output logic [`ACCEL_COUNT-1:0]                    m_axis_tlast,
  output logic [`ACCEL_COUNT-1:0]                    m_axis_tvalid,
  input  logic [`ACCEL_COUNT-1:0]                    m_axis_tready
);

  localparam int DATA_W = 8 * `LINE_BYTES;
  localparam int USER_W = $clog2(`LINE_BYTES);

  line_req_if     req_bus ();
  aligned_line_if line_bus ();

  // Accepted beats reported back for credits and busy flags
  dma_desc_pkg::accel_mask_t q_pop;
  dma_desc_pkg::accel_mask_t q_last;

  dma_ctrl i_dma_ctrl (
    .clk           (clk),
    .rst           (rst),
    .desc_accel_id (desc_accel_id),
    .desc_addr     (desc_addr),
    .desc_len      (desc_len),
    .desc_valid    (desc_valid),
    .pop           (q_pop),
    .pop_last      (q_last),
    .accel_busy    (accel_busy),
    .desc_error    (desc_error),
    .req           (req_bus.source)
  );

  bank_reader i_bank_reader (
    .clk           (clk),
    .rst           (rst),
    .req           (req_bus.sink),
    .bank0_rd_en   (bank0_rd_en),
    .bank0_rd_addr (bank0_rd_addr),
    .bank0_rd_data (bank0_rd_data),
    .bank1_rd_en   (bank1_rd_en),
    .bank1_rd_addr (bank1_rd_addr),
    .bank1_rd_data (bank1_rd_data),
    .line          (line_bus.source)
  );

  for (genvar g = 0; g < `ACCEL_COUNT; g++) begin : g_queue
    accel_out_queue #(
      .ACCEL_INDEX (g)
    ) i_accel_out_queue (
      .clk     (clk),
      .rst     (rst),
      .line    (line_bus.sink),
      .tdata   (m_axis_tdata[g*DATA_W +: DATA_W]),
      .tuser   (m_axis_tuser[g*USER_W +: USER_W]),
      .tlast   (m_axis_tlast[g]),
      .tvalid  (m_axis_tvalid[g]),
      .tready  (m_axis_tready[g]),
      .pop     (q_pop[g]),
      .is_last (q_last[g])
    );
  end

endmodule

//--- verification/accel_rd_dma_chk.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module accel_rd_dma_chk (
  input logic                                  clk,
  input logic                                  rst,
  input logic                                  bank0_rd_en,
  input logic                                  bank1_rd_en,
  input dma_desc_pkg::accel_mask_t             accel_busy,
  input dma_desc_pkg::accel_mask_t             desc_error,
  input logic [`ACCEL_COUNT*8*`LINE_BYTES-1:0] m_axis_tdata,
  input logic [`ACCEL_COUNT-1:0]               m_axis_tlast,
  input logic [`ACCEL_COUNT-1:0]               m_axis_tvalid,
  input logic [`ACCEL_COUNT-1:0]               m_axis_tready
);

  localparam int DATA_W = 8 * `LINE_BYTES;

  // Every fetch reads both banks together
  bank_enables_match: assert property (@(posedge clk) bank0_rd_en == bank1_rd_en)
    else $error("Bank read enables differ");

  for (genvar g = 0; g < `ACCEL_COUNT; g++) begin : g_stream
    held_beat_stable: assert property (@(posedge clk) disable iff (rst)
      m_axis_tvalid[g] && !m_axis_tready[g]
        |=> m_axis_tvalid[g] && $stable(m_axis_tdata[g*DATA_W +: DATA_W]))
      else $error("Stream %0d changed a beat that was not accepted", g);

    last_while_busy: assert property (@(posedge clk) disable iff (rst)
      m_axis_tvalid[g] && m_axis_tlast[g] |-> accel_busy[g])
      else $error("Stream %0d shows tlast while its busy flag is low", g);

    // Sticky until reset
    error_sticky: assert property (@(posedge clk) disable iff (rst)
      desc_error[g] |=> desc_error[g])
      else $error("Error flag %0d cleared without reset", g);
  end

endmodule

//--- verification/accel_rd_dma_tb.sv
`timescale 1ns/1ns
`include "rd_dma_defs.svh"

module accel_rd_dma_tb;
  import dma_desc_pkg::*;
  import spm_bank_pkg::*;

  localparam int DATA_W = 8 * `LINE_BYTES;
  localparam int USER_W = $clog2(`LINE_BYTES);
  localparam int BEAT_W = 1 + USER_W + DATA_W;

  // One stream beat packed as tlast, tuser, tdata
  typedef logic [BEAT_W-1:0] beat_t;

  logic                                clk;
  logic                                rst;
  accel_id_t                           desc_accel_id;
  byte_addr_t                          desc_addr;
  byte_len_t                           desc_len;
  logic                                desc_valid;
  accel_mask_t                         accel_busy;
  accel_mask_t                         desc_error;
  logic                                bank0_rd_en;
  bank_addr_t                          bank0_rd_addr;
  line_data_t                          bank0_rd_data;
  logic                                bank1_rd_en;
  bank_addr_t                          bank1_rd_addr;
  line_data_t                          bank1_rd_data;
  logic [`ACCEL_COUNT*DATA_W-1:0]      m_axis_tdata;
  logic [`ACCEL_COUNT*USER_W-1:0]      m_axis_tuser;
  logic [`ACCEL_COUNT-1:0]             m_axis_tlast;
  logic [`ACCEL_COUNT-1:0]             m_axis_tvalid;
  logic [`ACCEL_COUNT-1:0]             m_axis_tready;

  // Expected beats per accelerator with the head copied out on the falling edge
  beat_t       sb [`ACCEL_COUNT][$];
  beat_t       exp_head [`ACCEL_COUNT];
  logic        has_exp [`ACCEL_COUNT];
  bank_addr_t  bank0_addr_q;
  bank_addr_t  bank1_addr_q;
  line_data_t  bank0_line_q;
  line_data_t  bank1_line_q;
  logic [31:0] stim_rng;
  logic [31:0] ready_rng;
  logic        random_ready;
  int          beats_total;
  string       test_name;

  accel_rd_dma i_accel_rd_dma (.*);

  bind accel_rd_dma accel_rd_dma_chk i_accel_rd_dma_chk (
    .clk           (clk),
    .rst           (rst),
    .bank0_rd_en   (bank0_rd_en),
    .bank1_rd_en   (bank1_rd_en),
    .accel_busy    (accel_busy),
    .desc_error    (desc_error),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic logic [7:0] next_rand_byte_unused_guard(input logic [7:0] b);
    return b;
  endfunction

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Scratchpad byte pattern built from every address bit
  function automatic logic [7:0] mem_byte(input byte_addr_t a);
    int v;
    v = (int'(a) * 5 + 3) ^ (int'(a) >> 8);
    return v[7:0];
  endfunction

  function automatic line_data_t bank_line(input logic odd, input bank_addr_t idx);
    line_data_t data;
    for (int j = 0; j < `LINE_BYTES; j++) begin
      data[8*j +: 8] = mem_byte({idx, odd, 3'(j)});
    end
    return data;
  endfunction

  function automatic beat_t expected_beat(input byte_addr_t addr, input byte_len_t len,
                                          input int k);
    line_data_t data;
    byte_ptr_t  user;
    logic       last;
    last = (k == (int'(len) + 7) / 8 - 1);
    user = last ? byte_ptr_t'(int'(len) - 1) : '1;
    for (int j = 0; j < `LINE_BYTES; j++) begin
      data[8*j +: 8] = mem_byte(addr + byte_addr_t'(8 * k + j));
    end
    return {last, user, data};
  endfunction

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int i = 0; i < `ACCEL_COUNT; i++) begin
      n += sb[i].size();
    end
    return n;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Two-edge read latency on both banks
  always @(posedge clk) begin
    if (bank0_rd_en) begin
      bank0_addr_q <= bank0_rd_addr;
    end
    if (bank1_rd_en) begin
      bank1_addr_q <= bank1_rd_addr;
    end
    bank0_line_q <= bank_line(1'b0, bank0_addr_q);
    bank1_line_q <= bank_line(1'b1, bank1_addr_q);
  end

  // Read data reaches the DUT on the falling edge
  always @(negedge clk) begin
    bank0_rd_data = bank0_line_q;
    bank1_rd_data = bank1_line_q;
  end

  always @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        if (m_axis_tvalid[i] && m_axis_tready[i] && sb[i].size() != 0) begin
          void'(sb[i].pop_front());
        end
      end
    end
  end

  always @(negedge clk) begin
    for (int i = 0; i < `ACCEL_COUNT; i++) begin
      has_exp[i]  = (sb[i].size() != 0);
      exp_head[i] = has_exp[i] ? sb[i][0] : '0;
    end
  end

  for (genvar g = 0; g < `ACCEL_COUNT; g++) begin : g_check
    logic  beat;
    beat_t got;

    assign beat = m_axis_tvalid[g] && m_axis_tready[g];
    assign got  = {m_axis_tlast[g], m_axis_tuser[g*USER_W +: USER_W],
                   m_axis_tdata[g*DATA_W +: DATA_W]};

    beat_expected: assert property (@(posedge clk) disable iff (rst) beat |-> has_exp[g])
      else abort_run($sformatf("Accelerator %0d delivered a beat that no descriptor asked for",
                               g));

    beat_matches: assert property (@(posedge clk) disable iff (rst)
      beat && has_exp[g] |-> got == exp_head[g])
      else abort_run($sformatf("ERR %s accel %0d expected %h actual %h",
                               test_name, g, exp_head[g], $sampled(got)));
  end

  initial begin
    forever begin
      @(negedge clk);
      if (random_ready) begin
        ready_rng     = next_rand(ready_rng);
        m_axis_tready = ready_rng[3:0];
      end else begin
        m_axis_tready = '1;
      end
    end
  end

  // Allowance grows with every expected beat
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 500 + 40 * beats_total) begin
      @(posedge clk);
      cycles++;
    end
    abort_run("Watchdog timeout, the DUT stopped delivering beats");
  end

  task automatic send_desc(input int id, input byte_addr_t addr, input byte_len_t len,
                           input bit dropped);
    int beats;
    beats = (int'(len) + 7) / 8;
    @(negedge clk);
    desc_accel_id = accel_id_t'(id);
    desc_addr     = addr;
    desc_len      = len;
    desc_valid    = 1'b1;
    if (!dropped) begin
      for (int k = 0; k < beats; k++) begin
        sb[id].push_back(expected_beat(addr, len, k));
      end
      beats_total += beats;
    end
  endtask

  task automatic send_random(input int id);
    byte_addr_t addr;
    byte_len_t  len;
    stim_rng = next_rand(stim_rng);
    addr     = stim_rng[9:0];
    len      = byte_len_t'(stim_rng[21:16]) + 8'd1;
    if (addr[2:0] == 3'd0) begin
      addr[2:0] = 3'd3;
    end
    send_desc(id, addr, len, 1'b0);
  endtask

  task automatic end_descs();
    @(negedge clk);
    desc_valid = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (accel_busy != '0) begin
      @(negedge clk);
    end
  endtask

  initial begin : main_seq
    rst           = 1'b1;
    desc_accel_id = '0;
    desc_addr     = '0;
    desc_len      = '0;
    desc_valid    = 1'b0;
    m_axis_tready = '1;
    bank0_rd_data = '0;
    bank1_rd_data = '0;
    random_ready  = 1'b0;
    stim_rng      = 32'h58b6;
    ready_rng     = next_rand(32'h58b6);
    beats_total   = 0;
    test_name     = "reset";
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_name = "aligned";
    send_desc(0, 10'h040, 8'd8, 1'b0);
    end_descs();
    assert (accel_busy[0])
      else abort_run($sformatf("ERR %s busy0 expected 1 actual %b", test_name, accel_busy[0]));
    wait_idle();
    send_desc(0, 10'h100, 8'd40, 1'b0);
    end_descs();
    wait_idle();

    // Last lines wrap past the top of the scratchpad
    test_name = "unaligned";
    send_desc(1, 10'h3fb, 8'd21, 1'b0);
    end_descs();
    wait_idle();
    for (int i = 0; i < 12; i++) begin
      send_random(i % `ACCEL_COUNT);
      end_descs();
      wait_idle();
    end

    test_name = "concurrent";
    for (int i = 0; i < `ACCEL_COUNT; i++) begin
      send_random(i);
    end
    end_descs();
    wait_idle();

    test_name = "backpressure";
    @(posedge clk);
    random_ready = 1'b1;
    repeat (6) begin
      for (int i = 0; i < `ACCEL_COUNT; i++) begin
        send_random(i);
      end
      end_descs();
      wait_idle();
    end
    @(posedge clk);
    random_ready = 1'b0;

    // Second descriptor lands while accelerator 2 is still busy
    test_name = "busy_drop";
    send_desc(2, 10'h123, 8'd48, 1'b0);
    send_desc(2, 10'h200, 8'd16, 1'b1);
    end_descs();
    assert (desc_error == 4'b0100)
      else abort_run($sformatf("ERR %s desc_error expected 0100 actual %b",
                               test_name, desc_error));
    wait_idle();
    repeat (30) @(negedge clk);

    if (pending_beats() != 0) begin
      abort_run($sformatf("%0d expected beats were never delivered", pending_beats()));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/dma_desc_pkg.sv
hdl/spm_bank_pkg.sv
hdl/rd_dma_if.sv
hdl/dma_ctrl.sv
hdl/bank_reader.sv
hdl/accel_out_queue.sv
hdl/accel_rd_dma.sv
verification/accel_rd_dma_chk.sv
verification/accel_rd_dma_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the read DMA testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module accel_rd_dma_tb \
  --Mdir obj_dir \
  -o accel_rd_dma_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/accel_rd_dma_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
